/* axicb_cfg_pkg.sv */
//////////////////////////////////////////////////
// AXI read crossbar sizes and memory map
//////////////////////////////////////////////////

package axicb_cfg_pkg;

    // Agents on each side
    localparam int MST_NB    = 2;
    localparam int SLV_NB    = 2;
    localparam int MST_IDX_W = $clog2(MST_NB);
    localparam int SLV_IDX_W = $clog2(SLV_NB);

    // Channel field widths
    localparam int ADDR_W = 13;
    localparam int ID_W   = 4;
    localparam int DATA_W = 16;
    localparam int LEN_W  = 4;

    // Slave windows, bounds are inclusive
    localparam logic [ADDR_W-1:0] SLV0_START_ADDR = 13'd0;
    localparam logic [ADDR_W-1:0] SLV0_END_ADDR   = 13'd4095;
    localparam logic [ADDR_W-1:0] SLV1_START_ADDR = 13'd4096;
    localparam logic [ADDR_W-1:0] SLV1_END_ADDR   = 13'd8191;
    localparam logic [SLV_NB-1:0][ADDR_W-1:0] SLV_START_ADDRS = {SLV1_START_ADDR, SLV0_START_ADDR};
    localparam logic [SLV_NB-1:0][ADDR_W-1:0] SLV_END_ADDRS   = {SLV1_END_ADDR, SLV0_END_ADDR};

    // ID bit 3 carries the master index
    localparam logic [ID_W-1:0] MST_ID_FIELD = 4'h8;
    localparam logic [ID_W-1:0] MST0_ID_MASK = 4'h0;
    localparam logic [ID_W-1:0] MST1_ID_MASK = 4'h8;
    localparam logic [MST_NB-1:0][ID_W-1:0] MST_ID_MASKS = {MST1_ID_MASK, MST0_ID_MASK};

endpackage

/* axicb_chan_pkg.sv */
//////////////////////////////////////////////////
// AXI read channel payloads
//////////////////////////////////////////////////

package axicb_chan_pkg;

    // Read address channel, 21 bits
    typedef struct packed {
        logic [axicb_cfg_pkg::ADDR_W-1:0] araddr;
        logic [axicb_cfg_pkg::ID_W-1:0]   arid;
        logic [axicb_cfg_pkg::LEN_W-1:0]  arlen;
    } ar_chan_t;

    // Read data channel, 21 bits
    typedef struct packed {
        logic [axicb_cfg_pkg::DATA_W-1:0] rdata;
        logic [axicb_cfg_pkg::ID_W-1:0]   rid;
        logic                             rlast;
    } r_chan_t;

    // Outstanding read tracking in the master-side switch
    typedef enum logic {
        SW_IDLE   = 1'b0,
        SW_WAIT_R = 1'b1
    } slv_sw_state_t;

endpackage

/* axicb_rd_if.sv */
//////////////////////////////////////////////////
// AXI read link (AR + R)
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface axicb_rd_if;

    // Address request
    logic                     arvalid;
    logic                     arready;
    axicb_chan_pkg::ar_chan_t ar;

    // Data response
    logic                     rvalid;
    logic                     rready;
    axicb_chan_pkg::r_chan_t  r;

    modport mst (
        output arvalid,
        output ar,
        input  arready,
        input  rvalid,
        input  r,
        output rready
    );

    modport slv (
        input  arvalid,
        input  ar,
        output arready,
        output rvalid,
        output r,
        input  rready
    );

endinterface

`resetall

/* axicb_pipeline.sv */
//////////////////////////////////////////////////
// One-stage AR/R register slice
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axicb_pipeline (
    input  logic    aclk,
    input  logic    i_rst_n,
    axicb_rd_if.slv i_up,
    axicb_rd_if.mst i_dn
);

    logic                     ar_valid_q;
    axicb_chan_pkg::ar_chan_t ar_q;
    logic                     r_valid_q;
    axicb_chan_pkg::r_chan_t  r_q;
    logic                     ar_load;
    logic                     r_load;

    ///////////////////////////////////////////////////
    // AR toward the crossbar
    ///////////////////////////////////////////////////

    // Free when empty or when the held request leaves this cycle
    assign i_up.arready = !ar_valid_q || i_dn.arready;
    assign ar_load      = i_up.arvalid && i_up.arready;

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            ar_valid_q <= 1'b0;
        end else if (i_up.arready) begin
            ar_valid_q <= i_up.arvalid;
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_load) begin
            ar_q <= i_up.ar;
        end
    end

    assign i_dn.arvalid = ar_valid_q;
    assign i_dn.ar      = ar_q;

    ///////////////////////////////////////////////////
    // R back toward the master
    ///////////////////////////////////////////////////

    assign i_dn.rready = !r_valid_q || i_up.rready;
    assign r_load      = i_dn.rvalid && i_dn.rready;

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            r_valid_q <= 1'b0;
        end else if (i_dn.rready) begin
            r_valid_q <= i_dn.rvalid;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_load) begin
            r_q <= i_dn.r;
        end
    end

    assign i_up.rvalid = r_valid_q;
    assign i_up.r      = r_q;

    // Stalled outputs keep their payload
    ar_hold_a : assert property (@(posedge aclk) disable iff (!i_rst_n)
        ar_valid_q && !i_dn.arready |=> ar_valid_q && $stable(ar_q));
    r_hold_a : assert property (@(posedge aclk) disable iff (!i_rst_n)
        r_valid_q && !i_up.rready |=> r_valid_q && $stable(r_q));

endmodule

`resetall

/* axicb_rr_arbiter.sv */
//////////////////////////////////////////////////
// Round-robin arbiter with grant hold
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axicb_rr_arbiter (
    input  logic                            aclk,
    input  logic                            i_rst_n,
    input  logic [axicb_cfg_pkg::MST_NB-1:0] i_req,
    input  logic                            i_ack,
    output logic [axicb_cfg_pkg::MST_NB-1:0] o_grant
);

    typedef logic [axicb_cfg_pkg::MST_IDX_W-1:0] mst_idx_t;

    mst_idx_t                         last_q;
    mst_idx_t                         win_idx;
    logic                             hold_q;
    logic [axicb_cfg_pkg::MST_NB-1:0] grant_q;
    logic [axicb_cfg_pkg::MST_NB-1:0] pick;

    // First requester after the last winner, index wraps on MST_NB
    always_comb begin
        mst_idx_t idx;
        pick = '0;
        for (int k = 1; k <= axicb_cfg_pkg::MST_NB; k++) begin
            idx = last_q + mst_idx_t'(k);
            if (pick == '0 && i_req[idx]) begin
                pick[idx] = 1'b1;
            end
        end
    end

    assign o_grant = hold_q ? grant_q : pick;

    always_comb begin
        win_idx = last_q;
        for (int m = 0; m < axicb_cfg_pkg::MST_NB; m++) begin
            if (o_grant[m]) begin
                win_idx = mst_idx_t'(m);
            end
        end
    end

    // Lock the grant until the request is taken
    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            hold_q  <= 1'b0;
            grant_q <= '0;
            last_q  <= mst_idx_t'(axicb_cfg_pkg::MST_NB - 1);
        end else if (i_ack) begin
            hold_q <= 1'b0;
            last_q <= win_idx;
        end else if (|o_grant) begin
            hold_q  <= 1'b1;
            grant_q <= o_grant;
        end
    end

    grant_onehot_a : assert property (@(posedge aclk) disable iff (!i_rst_n)
        $onehot0(o_grant));

endmodule

`resetall

/* axicb_slv_switch.sv */
//////////////////////////////////////////////////
// Master-side switch: decode and R select
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axicb_slv_switch (
    input  logic    aclk,
    input  logic    i_rst_n,
    axicb_rd_if.slv i_mst,
    axicb_rd_if.mst o_slv [axicb_cfg_pkg::SLV_NB]
);

    typedef logic [axicb_cfg_pkg::SLV_IDX_W-1:0] slv_idx_t;

    axicb_chan_pkg::slv_sw_state_t    state_q;
    slv_idx_t                         tgt_q;
    slv_idx_t                         dec_idx;
    logic                             idle;
    logic                             ar_fire;
    logic                             r_done;
    logic [axicb_cfg_pkg::SLV_NB-1:0] hit;
    logic [axicb_cfg_pkg::SLV_NB-1:0] link_arready;
    logic [axicb_cfg_pkg::SLV_NB-1:0] link_rvalid;
    axicb_chan_pkg::r_chan_t          link_r [axicb_cfg_pkg::SLV_NB];

    assign idle = (state_q == axicb_chan_pkg::SW_IDLE);

    ///////////////////////////////////////////////////
    // Address decode and per-slave links
    ///////////////////////////////////////////////////

    for (genvar s = 0; s < axicb_cfg_pkg::SLV_NB; s++) begin : gen_link
        assign hit[s] = (i_mst.ar.araddr >= axicb_cfg_pkg::SLV_START_ADDRS[s]) &&
                        (i_mst.ar.araddr <= axicb_cfg_pkg::SLV_END_ADDRS[s]);

        assign o_slv[s].arvalid = i_mst.arvalid && idle && hit[s];
        assign o_slv[s].ar      = i_mst.ar;
        assign o_slv[s].rready  = !idle && (tgt_q == slv_idx_t'(s)) && i_mst.rready;

        assign link_arready[s] = o_slv[s].arready;
        assign link_rvalid[s]  = o_slv[s].rvalid;
        assign link_r[s]       = o_slv[s].r;
    end

    always_comb begin
        dec_idx = '0;
        for (int s = 0; s < axicb_cfg_pkg::SLV_NB; s++) begin
            if (hit[s]) begin
                dec_idx = slv_idx_t'(s);
            end
        end
    end

    // Single outstanding read, so only accept while idle
    assign i_mst.arready = idle && |(hit & link_arready);

    // R comes back from the recorded slave only
    assign i_mst.rvalid = !idle && link_rvalid[tgt_q];
    assign i_mst.r      = link_r[tgt_q];

    assign ar_fire = i_mst.arvalid && i_mst.arready;
    assign r_done  = i_mst.rvalid && i_mst.rready && i_mst.r.rlast;

    ///////////////////////////////////////////////////
    // Outstanding read FSM
    ///////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            state_q <= axicb_chan_pkg::SW_IDLE;
            tgt_q   <= '0;
        end else begin
            case (state_q)
                axicb_chan_pkg::SW_IDLE: begin
                    if (ar_fire) begin
                        state_q <= axicb_chan_pkg::SW_WAIT_R;
                        tgt_q   <= dec_idx;
                    end
                end
                axicb_chan_pkg::SW_WAIT_R: begin
                    if (r_done) begin
                        state_q <= axicb_chan_pkg::SW_IDLE;
                    end
                end
                default: state_q <= axicb_chan_pkg::SW_IDLE;
            endcase
        end
    end

    // ID routing in the slave-side switch never hands us a beat while idle
    idle_no_r_a : assert property (@(posedge aclk) disable iff (!i_rst_n)
        idle |-> (link_rvalid == '0));

endmodule

`resetall

/* axicb_mst_switch.sv */
//////////////////////////////////////////////////
// Slave-side switch: AR arbitration, R routing
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axicb_mst_switch (
    input  logic    aclk,
    input  logic    i_rst_n,
    axicb_rd_if.slv i_mst [axicb_cfg_pkg::MST_NB],
    axicb_rd_if.mst o_slv
);

    typedef logic [axicb_cfg_pkg::MST_IDX_W-1:0] mst_idx_t;

    logic [axicb_cfg_pkg::MST_NB-1:0] req;
    logic [axicb_cfg_pkg::MST_NB-1:0] grant;
    logic [axicb_cfg_pkg::MST_NB-1:0] rdst;
    logic [axicb_cfg_pkg::MST_NB-1:0] rready_arr;
    axicb_chan_pkg::ar_chan_t         ar_arr [axicb_cfg_pkg::MST_NB];
    mst_idx_t                         gnt_idx;
    logic                             ar_ack;

    ///////////////////////////////////////////////////
    // Per-master links
    ///////////////////////////////////////////////////

    for (genvar m = 0; m < axicb_cfg_pkg::MST_NB; m++) begin : gen_link
        assign req[m]        = i_mst[m].arvalid;
        assign ar_arr[m]     = i_mst[m].ar;
        assign rready_arr[m] = i_mst[m].rready;

        // Beat belongs to the master whose mask matches the ID field
        assign rdst[m] = ((o_slv.r.rid & axicb_cfg_pkg::MST_ID_FIELD) ==
                          axicb_cfg_pkg::MST_ID_MASKS[m]);

        assign i_mst[m].arready = grant[m] && o_slv.arready;
        assign i_mst[m].rvalid  = o_slv.rvalid && rdst[m];
        assign i_mst[m].r       = o_slv.r;
    end

    ///////////////////////////////////////////////////
    // AR arbitration
    ///////////////////////////////////////////////////

    assign ar_ack = o_slv.arvalid && o_slv.arready;

    axicb_rr_arbiter ar_arbiter (
        .aclk    (aclk),
        .i_rst_n (i_rst_n),
        .i_req   (req),
        .i_ack   (ar_ack),
        .o_grant (grant)
    );

    always_comb begin
        gnt_idx = '0;
        for (int m = 0; m < axicb_cfg_pkg::MST_NB; m++) begin
            if (grant[m]) begin
                gnt_idx = mst_idx_t'(m);
            end
        end
    end

    assign o_slv.arvalid = |(grant & req);
    assign o_slv.ar      = ar_arr[gnt_idx];

    // Backpressure comes from the addressed master only
    assign o_slv.rready = |(rdst & rready_arr);

endmodule

`resetall

/* axicb_rd_switch_top.sv */
//////////////////////////////////////////////////
// AXI read crossbar, 2 masters x 2 slaves
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axicb_rd_switch_top (
    input  logic                     aclk,
    input  logic                     i_rst_n,
    // Master ports
    input  logic                     i_m_arvalid [axicb_cfg_pkg::MST_NB],
    input  axicb_chan_pkg::ar_chan_t i_m_ar      [axicb_cfg_pkg::MST_NB],
    input  logic                     i_m_rready  [axicb_cfg_pkg::MST_NB],
    output logic                     o_m_arready [axicb_cfg_pkg::MST_NB],
    output logic                     o_m_rvalid  [axicb_cfg_pkg::MST_NB],
    output axicb_chan_pkg::r_chan_t  o_m_r       [axicb_cfg_pkg::MST_NB],
    // Slave ports
    output logic                     o_s_arvalid [axicb_cfg_pkg::SLV_NB],
    output axicb_chan_pkg::ar_chan_t o_s_ar      [axicb_cfg_pkg::SLV_NB],
    output logic                     o_s_rready  [axicb_cfg_pkg::SLV_NB],
    input  logic                     i_s_arready [axicb_cfg_pkg::SLV_NB],
    input  logic                     i_s_rvalid  [axicb_cfg_pkg::SLV_NB],
    input  axicb_chan_pkg::r_chan_t  i_s_r       [axicb_cfg_pkg::SLV_NB]
);

    ///////////////////////////////////////////////////
    // Master side: port, register slice, decoder
    ///////////////////////////////////////////////////

    for (genvar m = 0; m < axicb_cfg_pkg::MST_NB; m++) begin : gen_mst
        axicb_rd_if port_if ();
        axicb_rd_if pipe_if ();
        // Row m of the switch matrix, one link per slave
        axicb_rd_if link [axicb_cfg_pkg::SLV_NB] ();

        assign port_if.arvalid = i_m_arvalid[m];
        assign port_if.ar      = i_m_ar[m];
        assign port_if.rready  = i_m_rready[m];
        assign o_m_arready[m]  = port_if.arready;
        assign o_m_rvalid[m]   = port_if.rvalid;
        assign o_m_r[m]        = port_if.r;

        axicb_pipeline mst_pipe (
            .aclk    (aclk),
            .i_rst_n (i_rst_n),
            .i_up    (port_if),
            .i_dn    (pipe_if)
        );

        axicb_slv_switch slv_switch (
            .aclk    (aclk),
            .i_rst_n (i_rst_n),
            .i_mst   (pipe_if),
            .o_slv   (link)
        );
    end

    ///////////////////////////////////////////////////
    // Slave side: column view of the matrix, arbiter
    ///////////////////////////////////////////////////

    for (genvar s = 0; s < axicb_cfg_pkg::SLV_NB; s++) begin : gen_slv
        axicb_rd_if port_if ();
        axicb_rd_if col [axicb_cfg_pkg::MST_NB] ();

        for (genvar m = 0; m < axicb_cfg_pkg::MST_NB; m++) begin : gen_col
            assign col[m].arvalid = gen_mst[m].link[s].arvalid;
            assign col[m].ar      = gen_mst[m].link[s].ar;
            assign col[m].rready  = gen_mst[m].link[s].rready;

            assign gen_mst[m].link[s].arready = col[m].arready;
            assign gen_mst[m].link[s].rvalid  = col[m].rvalid;
            assign gen_mst[m].link[s].r       = col[m].r;
        end

        axicb_mst_switch mst_switch (
            .aclk    (aclk),
            .i_rst_n (i_rst_n),
            .i_mst   (col),
            .o_slv   (port_if)
        );

        assign o_s_arvalid[s]  = port_if.arvalid;
        assign o_s_ar[s]       = port_if.ar;
        assign o_s_rready[s]   = port_if.rready;
        assign port_if.arready = i_s_arready[s];
        assign port_if.rvalid  = i_s_rvalid[s];
        assign port_if.r       = i_s_r[s];
    end

endmodule

`resetall

/* tb_axicb_slave_model.sv */
//////////////////////////////////////////////////
// Behavioral AXI read slave
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_axicb_slave_model #(
    parameter int SLV_IDX = 0
) (
    input  logic                     aclk,
    input  logic                     i_rst_n,
    input  logic                     i_arvalid,
    input  axicb_chan_pkg::ar_chan_t i_ar,
    output logic                     o_arready,
    output logic                     o_rvalid,
    output axicb_chan_pkg::r_chan_t  o_r,
    input  logic                     i_rready
);

    axicb_chan_pkg::ar_chan_t pend_q [$];
    axicb_chan_pkg::ar_chan_t ar_seen;
    integer                   seed;
    int                       beat;
    logic                     in_reset;
    logic                     ar_fire;
    logic                     r_fire;

    initial begin
        seed      = 32'h98fd;
        beat      = 0;
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_r       = '0;
        forever begin
            // Sample mid-cycle, the transfer happens on the next edge
            @(negedge aclk);
            in_reset = !i_rst_n;
            ar_fire  = i_arvalid && o_arready;
            r_fire   = o_rvalid && i_rready;
            ar_seen  = i_ar;
            @(posedge aclk);
            #1;
            if (in_reset) begin
                pend_q.delete();
                beat      = 0;
                o_arready = 1'b0;
                o_rvalid  = 1'b0;
            end else begin
                if (ar_fire) begin
                    pend_q.push_back(ar_seen);
                end
                if (r_fire) begin
                    o_rvalid = 1'b0;
                    if (o_r.rlast) begin
                        void'(pend_q.pop_front());
                        beat = 0;
                    end else begin
                        beat++;
                    end
                end
                // Oldest request answers first, with random gaps
                if (!o_rvalid && pend_q.size() > 0 && ($random(seed) & 3) != 0) begin
                    o_rvalid    = 1'b1;
                    o_r.rdata   = 16'(SLV_IDX * 4096 + int'(pend_q[0].araddr[11:0]) + beat);
                    o_r.rid     = pend_q[0].arid;
                    o_r.rlast   = (beat == int'(pend_q[0].arlen));
                end
                o_arready = ($random(seed) & 3) != 0;
            end
        end
    end

endmodule

/* tb_axicb_rd_switch_top.sv */
//////////////////////////////////////////////////
// AXI read crossbar testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_axicb_rd_switch_top;

    localparam int CASE_NB   = 18;
    localparam int TIMEOUT   = 2000;
    localparam int DRIVE_DLY = 1;
    localparam int WIN_SIZE  = 4096;
    localparam int MST_NB    = axicb_cfg_pkg::MST_NB;
    localparam int SLV_NB    = axicb_cfg_pkg::SLV_NB;

    logic                     aclk;
    logic                     rst_n;
    logic                     m_arvalid [MST_NB];
    axicb_chan_pkg::ar_chan_t m_ar      [MST_NB];
    logic                     m_rready  [MST_NB];
    logic                     m_arready [MST_NB];
    logic                     m_rvalid  [MST_NB];
    axicb_chan_pkg::r_chan_t  m_r       [MST_NB];
    logic                     s_arvalid [SLV_NB];
    axicb_chan_pkg::ar_chan_t s_ar      [SLV_NB];
    logic                     s_rready  [SLV_NB];
    logic                     s_arready [SLV_NB];
    logic                     s_rvalid  [SLV_NB];
    axicb_chan_pkg::r_chan_t  s_r       [SLV_NB];

    // Four words per case for master, address, id and length
    logic [15:0] case_mem [4*CASE_NB];
    int          mlist    [MST_NB][CASE_NB];
    int          mcnt     [MST_NB];
    logic        busy     [MST_NB];
    // Master index of every AR seen at each slave in arrival order
    int          ar_order [SLV_NB][CASE_NB];
    int          ar_cnt   [SLV_NB];
    // Expected AR count and last winner per slave
    int          exp_cnt  [SLV_NB];
    int          last_win [SLV_NB];
    integer      seed;

    axicb_rd_switch_top axicb_rd_switch_top_i (
        .aclk        (aclk),
        .i_rst_n     (rst_n),
        .i_m_arvalid (m_arvalid),
        .i_m_ar      (m_ar),
        .i_m_rready  (m_rready),
        .o_m_arready (m_arready),
        .o_m_rvalid  (m_rvalid),
        .o_m_r       (m_r),
        .o_s_arvalid (s_arvalid),
        .o_s_ar      (s_ar),
        .o_s_rready  (s_rready),
        .i_s_arready (s_arready),
        .i_s_rvalid  (s_rvalid),
        .i_s_r       (s_r)
    );

    for (genvar s = 0; s < SLV_NB; s++) begin : gen_slave
        tb_axicb_slave_model #(.SLV_IDX(s)) slave_model (
            .aclk      (aclk),
            .i_rst_n   (rst_n),
            .i_arvalid (s_arvalid[s]),
            .i_ar      (s_ar[s]),
            .o_arready (s_arready[s]),
            .o_rvalid  (s_rvalid[s]),
            .o_r       (s_r[s]),
            .i_rready  (s_rready[s])
        );
    end

    initial aclk = 1'b0;
    always #50 aclk = ~aclk;

    ///////////////////////////////////////////////////
    // Checking helpers
    ///////////////////////////////////////////////////

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string sig, input int exp, input int act);
        assert (act == exp) else begin
            $display("FAILED at time %0t: %s expected %0h, got %0h", $time, sig, exp, act);
            abort_run();
        end
    endtask

    task automatic check_idle(input string phase);
        for (int s = 0; s < SLV_NB; s++) begin
            check_value($sformatf("o_s_arvalid[%0d] %s", s, phase), 0, int'(s_arvalid[s]));
        end
        for (int m = 0; m < MST_NB; m++) begin
            check_value($sformatf("o_m_rvalid[%0d] %s", m, phase), 0, int'(m_rvalid[m]));
        end
    endtask

    // One 4 KiB window per slave
    function automatic int slave_of(input int addr);
        return (addr > int'(axicb_cfg_pkg::SLV0_END_ADDR)) ? 1 : 0;
    endfunction

    ///////////////////////////////////////////////////
    // One read burst from one master
    ///////////////////////////////////////////////////

    task automatic run_read(input int m, input int c);
        int   addr;
        int   id;
        int   len;
        int   slv;
        int   beat;
        int   cyc;
        logic accepted;
        addr = int'(case_mem[4*c+1][12:0]);
        id   = int'(case_mem[4*c+2][3:0]);
        len  = int'(case_mem[4*c+3][3:0]);
        slv  = slave_of(addr);
        busy[m] = 1'b1;
        @(posedge aclk);
        #DRIVE_DLY;
        m_arvalid[m]   = 1'b1;
        m_ar[m].araddr = 13'(addr);
        m_ar[m].arid   = 4'(id);
        m_ar[m].arlen  = 4'(len);
        accepted = 1'b0;
        cyc = 0;
        while (!accepted && cyc < TIMEOUT) begin
            @(negedge aclk);
            accepted = m_arready[m];
            cyc++;
        end
        assert (accepted) else begin
            $display("Timeout: master %0d read of address %0h was never accepted", m, addr);
            abort_run();
        end
        @(posedge aclk);
        #DRIVE_DLY;
        m_arvalid[m] = 1'b0;
        beat = 0;
        cyc = 0;
        while (beat <= len && cyc < TIMEOUT) begin
            m_rready[m] = ($random(seed) & 3) != 0;
            @(negedge aclk);
            if (m_rvalid[m] && m_rready[m]) begin
                check_value($sformatf("o_m_r[%0d].rdata", m),
                            slv * WIN_SIZE + addr % WIN_SIZE + beat, int'(m_r[m].rdata));
                check_value($sformatf("o_m_r[%0d].rid", m), id, int'(m_r[m].rid));
                check_value($sformatf("o_m_r[%0d].rlast", m),
                            (beat == len) ? 1 : 0, int'(m_r[m].rlast));
                beat++;
            end
            cyc++;
            @(posedge aclk);
            #DRIVE_DLY;
        end
        assert (beat > len) else begin
            $display("Timeout: master %0d got %0d of %0d beats", m, beat, len + 1);
            abort_run();
        end
        m_rready[m] = 1'b0;
        busy[m]     = 1'b0;
    endtask

    // Both masters on one slave means the one that did not win last goes first
    task automatic verify_round(input int r);
        int tgt [MST_NB];
        int s;
        for (int m = 0; m < MST_NB; m++) begin
            tgt[m] = -1;
            if (r < mcnt[m]) begin
                tgt[m] = slave_of(int'(case_mem[4*mlist[m][r]+1][12:0]));
                exp_cnt[tgt[m]]++;
            end
        end
        for (int k = 0; k < SLV_NB; k++) begin
            check_value($sformatf("AR count at slave %0d, round %0d", k, r),
                        exp_cnt[k], ar_cnt[k]);
        end
        s = tgt[0];
        if (s >= 0 && s == tgt[1]) begin
            if (last_win[s] >= 0) begin
                check_value($sformatf("first AR master at slave %0d, round %0d", s, r),
                            1 - last_win[s], ar_order[s][ar_cnt[s]-2]);
                check_value($sformatf("second AR master at slave %0d, round %0d", s, r),
                            last_win[s], ar_order[s][ar_cnt[s]-1]);
            end
        end else begin
            for (int m = 0; m < MST_NB; m++) begin
                if (tgt[m] >= 0) begin
                    last_win[tgt[m]] = m;
                end
            end
        end
    endtask

    ///////////////////////////////////////////////////
    // Bus monitor
    ///////////////////////////////////////////////////

    always @(negedge aclk) begin
        if (!rst_n) begin
            for (int s = 0; s < SLV_NB; s++) begin
                ar_cnt[s] = 0;
            end
        end else begin
            for (int m = 0; m < MST_NB; m++) begin
                if (m_rvalid[m]) begin
                    check_value($sformatf("o_m_r[%0d].rid[3]", m), m, int'(m_r[m].rid[3]));
                    assert (busy[m]) else begin
                        $display("Master %0d got a beat with no read outstanding", m);
                        abort_run();
                    end
                end
            end
            for (int s = 0; s < SLV_NB; s++) begin
                if (s_arvalid[s] && s_arready[s] && ar_cnt[s] < CASE_NB) begin
                    check_value($sformatf("decode of o_s_ar[%0d].araddr", s),
                                s, slave_of(int'(s_ar[s].araddr)));
                    ar_order[s][ar_cnt[s]] = int'(s_ar[s].arid[3]);
                    ar_cnt[s]++;
                end
            end
        end
    end

    ///////////////////////////////////////////////////
    // Main sequence
    ///////////////////////////////////////////////////

    initial begin
        int mst;
        int rounds;
        seed  = 32'h98fd;
        rst_n = 1'b0;
        for (int m = 0; m < MST_NB; m++) begin
            m_arvalid[m] = 1'b0;
            m_ar[m]      = '0;
            m_rready[m]  = 1'b0;
            busy[m]      = 1'b0;
            mcnt[m]      = 0;
        end
        for (int s = 0; s < SLV_NB; s++) begin
            exp_cnt[s]  = 0;
            last_win[s] = -1;
        end
        $readmemh("axicb_rd_cases.txt", case_mem);
        for (int c = 0; c < CASE_NB; c++) begin
            mst = int'(case_mem[4*c]);
            assert (mst < MST_NB) else begin
                $display("Case %0d names master %0d, which does not exist", c, mst);
                abort_run();
            end
            mlist[mst][mcnt[mst]] = c;
            mcnt[mst]++;
        end

        // Outputs stay quiet over the three reset edges
        repeat (2) begin
            @(posedge aclk);
            @(negedge aclk);
            check_idle("in reset");
        end
        @(posedge aclk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge aclk);
        check_idle("after reset");

        // Both masters start each round on the same cycle
        rounds = (mcnt[0] > mcnt[1]) ? mcnt[0] : mcnt[1];
        for (int r = 0; r < rounds; r++) begin
            fork
                if (r < mcnt[0]) run_read(0, mlist[0][r]);
                if (r < mcnt[1]) run_read(1, mlist[1][r]);
            join
            verify_round(r);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* axicb_rd_cases.txt */
// master araddr arid arlen, all hex, one read per line
// n-th lines of each master run together in round n
0 0010 1 3
1 1020 9 2
0 1100 2 0
1 0200 a 1
0 0ff0 3 7
1 0400 b 4
0 0800 4 2
1 0001 c 3
0 1ffc 5 3
1 1000 d 5
0 0123 6 f
1 1abc e f
0 1fff 7 0
1 1800 f 1
0 0fff 0 1
1 0000 8 2
0 1001 3 4
1 0ffe 9 6

/* vlog.f */
axicb_cfg_pkg.sv
axicb_chan_pkg.sv
axicb_rd_if.sv
axicb_pipeline.sv
axicb_rr_arbiter.sv
axicb_slv_switch.sv
axicb_mst_switch.sv
axicb_rd_switch_top.sv
tb_axicb_slave_model.sv
tb_axicb_rd_switch_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the crossbar testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axicb_rd_switch_top -f vlog.f -o sim_axicb \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_axicb > sim.log 2>&1
cat sim.log
test -s sim.log || { echo "No simulation log"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0
